/* design/cpu_bus_if.sv */
`default_nettype none

`include "f2_defines.svh"

interface cpu_bus_if;

    logic [`F2_ADDR_W-1:0] addr;
    logic [1:0]            ds_n;  // Upper, lower
    logic                  rw;    // 1 - read
    logic [2:0]            fc;
    f2_pkg::cpu_data_t     dout;  // CPU write data

    modport decode (input addr, ds_n);

    modport sdram (input addr, ds_n, rw, dout);

    modport irq (input addr, ds_n, fc);

endinterface

`default_nettype wire

/* design/f2_addr_decode.sv */
`default_nettype none

module f2_addr_decode (
    cpu_bus_if.decode              bus,

    input  wire f2_pkg::cpu_data_t scn_dout,
    input  wire f2_pkg::cpu_data_t obj_dout,
    input  wire f2_pkg::cpu_data_t color_dout,
    input  wire [7:0]              io_dout,
    input  wire [3:0]              sound_dout,
    input  wire f2_pkg::cpu_data_t sdr_q,

    output f2_pkg::chip_sel_t      sel,
    output f2_pkg::cpu_data_t      cpu_din
);

    f2_pkg::word_addr_t word_addr;
    logic               bus_active;

    assign word_addr  = {bus.addr, 1'b0};
    assign bus_active = ~&bus.ds_n; // Either strobe low

    ////////////////////////////////////////////////////////////////////////////
    // Chip selects

    always_comb begin
        sel = '1;

        if (bus_active) begin
            case (word_addr[23:20])
                4'h0: sel.rom_n    = 1'b0;
                4'h1: sel.work_n   = 1'b0;
                4'h2: sel.color_n  = 1'b0;
                4'h8: sel.screen_n = 1'b0;
                4'h9: sel.object_n = 1'b0;
                4'h3: begin
                    // Only 30xxxx and 32xxxx are populated
                    if (word_addr[19:16] == 4'h0) begin
                        sel.io_n = 1'b0;
                    end else if (word_addr[19:16] == 4'h2) begin
                        sel.sound_n = 1'b0;
                    end
                end
                default: begin
                    sel = '1;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data

    always_comb begin
        if (~sel.rom_n || ~sel.work_n) begin
            cpu_din = sdr_q;
        end else if (~sel.screen_n) begin
            cpu_din = scn_dout;
        end else if (~sel.object_n) begin
            cpu_din = obj_dout;
        end else if (~sel.color_n) begin
            cpu_din = color_dout;
        end else if (~sel.io_n) begin
            cpu_din = {8'd0, io_dout};
        end else if (~sel.sound_n) begin
            cpu_din = {4'd0, sound_dout, 8'd0}; // Sound comms on D11..D8
        end else begin
            cpu_din = '0;
        end
    end

endmodule

`default_nettype wire

/* design/f2_cpu_bus.sv */
`default_nettype none

`include "f2_defines.svh"

module f2_cpu_bus (
    input  wire                        clk,
    input  wire                        reset,

    // 68000 bus
    input  wire [`F2_ADDR_W-1:0]       cpu_addr,
    input  wire [1:0]                  cpu_ds_n,
    input  wire                        cpu_rw,
    input  wire [2:0]                  cpu_fc,
    input  wire f2_pkg::cpu_data_t     cpu_dout,
    output f2_pkg::cpu_data_t          cpu_din,
    output logic                       cpu_dtack_n,
    output logic [2:0]                 cpu_ipl_n,
    output logic                       cpu_vpa_n,

    // Peripherals
    input  wire f2_pkg::cpu_data_t     scn_dout,
    input  wire f2_pkg::cpu_data_t     obj_dout,
    input  wire f2_pkg::cpu_data_t     color_dout,
    input  wire [7:0]                  io_dout,
    input  wire [3:0]                  sound_dout,
    input  wire                        scn_dtack_n,
    input  wire                        color_dtack_n,
    input  wire                        obj_busy,
    output logic                       scn_cs_n,
    output logic                       obj_cs_n,
    output logic                       color_cs_n,
    output logic                       io_cs_n,
    output logic                       sound_cs_n,

    input  wire                        vblank_n,
    input  wire                        dma_n,

    // SDRAM CPU port
    output logic [`F2_SDR_ADDR_W-1:0]  sdr_addr,
    output f2_pkg::cpu_data_t          sdr_data,
    output logic [1:0]                 sdr_be,
    output logic                       sdr_rw,
    output logic                       sdr_req,
    input  wire f2_pkg::cpu_data_t     sdr_q,
    input  wire                        sdr_ack
);

    f2_pkg::chip_sel_t sel;

    cpu_bus_if bus ();

    assign bus.addr = cpu_addr;
    assign bus.ds_n = cpu_ds_n;
    assign bus.rw   = cpu_rw;
    assign bus.fc   = cpu_fc;
    assign bus.dout = cpu_dout;

    ////////////////////////////////////////////////////////////////////////////
    // Decode

    f2_addr_decode u_decode (
        .bus        (bus.decode),
        .scn_dout   (scn_dout),
        .obj_dout   (obj_dout),
        .color_dout (color_dout),
        .io_dout    (io_dout),
        .sound_dout (sound_dout),
        .sdr_q      (sdr_q),
        .sel        (sel),
        .cpu_din    (cpu_din)
    );

    assign scn_cs_n   = sel.screen_n;
    assign obj_cs_n   = sel.object_n;
    assign color_cs_n = sel.color_n;
    assign io_cs_n    = sel.io_n;
    assign sound_cs_n = sel.sound_n;

    ////////////////////////////////////////////////////////////////////////////
    // ROM / work RAM and DTACK

    f2_sdram_port u_sdram (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus.sdram),
        .sel           (sel),
        .sdr_addr      (sdr_addr),
        .sdr_data      (sdr_data),
        .sdr_be        (sdr_be),
        .sdr_rw        (sdr_rw),
        .sdr_req       (sdr_req),
        .sdr_ack       (sdr_ack),
        .scn_dtack_n   (scn_dtack_n),
        .color_dtack_n (color_dtack_n),
        .obj_busy      (obj_busy),
        .cpu_dtack_n   (cpu_dtack_n)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Interrupts

    f2_irq_ctrl u_irq (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus.irq),
        .vblank_n  (vblank_n),
        .dma_n     (dma_n),
        .cpu_ipl_n (cpu_ipl_n),
        .cpu_vpa_n (cpu_vpa_n)
    );

endmodule

`default_nettype wire

/* design/f2_irq_ctrl.sv */
`default_nettype none

`include "f2_defines.svh"

module f2_irq_ctrl (
    input  wire        clk,
    input  wire        reset,

    cpu_bus_if.irq     bus,

    input  wire        vblank_n,
    input  wire        dma_n,

    output logic [2:0] cpu_ipl_n,
    output logic       cpu_vpa_n
);

    logic               vbl_prev;
    logic               dma_prev;
    logic               vbl_pend;
    logic               dma_pend;
    logic               iack;
    logic               vbl_clr;
    logic               dma_clr;
    f2_pkg::irq_level_t level;

    // FC = 7 is an interrupt acknowledge
    assign iack = &bus.fc;

    assign vbl_clr = iack & ~bus.ds_n[0] & (bus.addr[2:0] == `F2_IRQ_VBL);
    assign dma_clr = iack & ~bus.ds_n[0] & (bus.addr[2:0] == `F2_IRQ_DMA);

    always_ff @(posedge clk) begin
        vbl_prev <= vblank_n;
        dma_prev <= dma_n;

        if (reset) begin
            vbl_pend <= 1'b0;
            dma_pend <= 1'b0;
        end else begin
            if (vbl_prev & ~vblank_n) begin
                vbl_pend <= 1'b1;   // Falling edge of blank
            end
            if (~dma_prev & dma_n) begin
                dma_pend <= 1'b1;   // DMA finished
            end

            // Acknowledge wins over a new edge
            if (vbl_clr) begin
                vbl_pend <= 1'b0;
            end
            if (dma_clr) begin
                dma_pend <= 1'b0;
            end
        end
    end

    assign level = dma_pend ? `F2_IRQ_DMA :
                   vbl_pend ? `F2_IRQ_VBL :
                   3'd0;

    assign cpu_ipl_n = ~level;
    assign cpu_vpa_n = ~(iack & ~&bus.ds_n); // Autovector every acknowledge

endmodule

`default_nettype wire

/* design/f2_pkg.sv */
`default_nettype none

`include "f2_defines.svh"

package f2_pkg;

    // Byte address, A0 always zero
    typedef logic [`F2_ADDR_W:0] word_addr_t;

    typedef logic [`F2_DATA_W-1:0] cpu_data_t;

    // All selects active low
    typedef struct packed {
        logic rom_n;
        logic work_n;
        logic screen_n;
        logic object_n;
        logic color_n;
        logic io_n;
        logic sound_n;
    } chip_sel_t;

    typedef logic [2:0] irq_level_t;

endpackage

`default_nettype wire

/* design/f2_sdram_port.sv */
`default_nettype none

`include "f2_defines.svh"

module f2_sdram_port (
    input  wire                        clk,
    input  wire                        reset,

    cpu_bus_if.sdram                   bus,
    input  wire f2_pkg::chip_sel_t     sel,

    output logic [`F2_SDR_ADDR_W-1:0]  sdr_addr,
    output f2_pkg::cpu_data_t          sdr_data,
    output logic [1:0]                 sdr_be,
    output logic                       sdr_rw,   // 1 - read
    output logic                       sdr_req,
    input  wire                        sdr_ack,

    input  wire                        scn_dtack_n,
    input  wire                        color_dtack_n,
    input  wire                        obj_busy,
    output logic                       cpu_dtack_n
);

    f2_pkg::word_addr_t word_addr;
    logic               prev_idle;  // Strobes were both high last cycle
    logic               mem_sel;
    logic               sdr_start;
    logic               sdr_busy;
    logic               obj_stall;

    assign word_addr = {bus.addr, 1'b0};
    assign mem_sel   = ~sel.rom_n | ~sel.work_n;

    // First cycle of a ROM / work RAM access
    assign sdr_start = mem_sel & prev_idle;

    ////////////////////////////////////////////////////////////////////////////
    // Request toggle

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_idle <= 1'b1;
            sdr_req   <= 1'b0;
        end else begin
            prev_idle <= &bus.ds_n;
            if (sdr_start) begin
                sdr_req <= ~sdr_req;
            end
        end
    end

    // Held for as long as the request is outstanding
    always_ff @(posedge clk) begin
        if (sdr_start) begin
            sdr_addr <= `F2_CPU_ROM_SDR_BASE + `F2_SDR_ADDR_W'(word_addr);
            sdr_data <= bus.dout;
            sdr_be   <= ~bus.ds_n;
            sdr_rw   <= bus.rw;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // DTACK

    // The start cycle counts as outstanding, the toggle lands on the next edge
    assign sdr_busy  = sdr_start | (sdr_req != sdr_ack);
    assign obj_stall = obj_busy & ~sel.object_n;   // Object chip owns its RAM

    assign cpu_dtack_n = sdr_busy | scn_dtack_n | color_dtack_n | obj_stall;

endmodule

`default_nettype wire

/* include/f2_defines.svh */
`ifndef F2_DEFINES_SVH
`define F2_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths

// 68000 word address, A23..A1
`define F2_ADDR_W 23

`define F2_DATA_W 16

// SDRAM byte address
`define F2_SDR_ADDR_W 27

////////////////////////////////////////////////////////////////////////////
// Memory map

// CPU address zero in SDRAM, ROM and work RAM follow on linearly
`define F2_CPU_ROM_SDR_BASE 27'h040_0000

////////////////////////////////////////////////////////////////////////////
// Interrupt levels

`define F2_IRQ_VBL 3'd5 // Vertical blank
`define F2_IRQ_DMA 3'd6 // Object DMA done

`endif

/* sim.f */
+incdir+include
design/f2_pkg.sv
design/cpu_bus_if.sv
design/f2_addr_decode.sv
design/f2_sdram_port.sv
design/f2_irq_ctrl.sv
design/f2_cpu_bus.sv
test/tb_f2_cpu_bus.sv

/* test/tb_f2_cpu_bus.sv */
`default_nettype none

`include "f2_defines.svh"

module tb_f2_cpu_bus;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROUNDS     = 6;
    localparam int BUS_CYCLES = 8 * ROUNDS + 2;   // Every region per round, two IACKs
    localparam int R_ROM = 0, R_WORK = 1, R_SCREEN = 2, R_OBJECT = 3;
    localparam int R_COLOR = 4, R_IO = 5, R_SOUND = 6, R_NONE = 7;

    logic                       clk = 1'b0;
    logic                       reset = 1'b1;
    logic [`F2_ADDR_W-1:0]      cpu_addr = '0;
    logic [1:0]                 cpu_ds_n = 2'b11;
    logic                       cpu_rw = 1'b1;
    logic [2:0]                 cpu_fc = 3'b101;
    f2_pkg::cpu_data_t          cpu_dout = '0;
    f2_pkg::cpu_data_t          scn_dout = '0;
    f2_pkg::cpu_data_t          obj_dout = '0;
    f2_pkg::cpu_data_t          color_dout = '0;
    logic [7:0]                 io_dout = '0;
    logic [3:0]                 sound_dout = '0;
    logic                       scn_dtack_n = 1'b0;
    logic                       color_dtack_n = 1'b0;
    logic                       obj_busy = 1'b0;
    logic                       vblank_n = 1'b1;
    logic                       dma_n = 1'b0;
    f2_pkg::cpu_data_t          sdr_q = '0;
    logic                       sdr_ack = 1'b0;
    f2_pkg::cpu_data_t          cpu_din;
    logic                       cpu_dtack_n;
    logic [2:0]                 cpu_ipl_n;
    logic                       cpu_vpa_n;
    logic                       scn_cs_n;
    logic                       obj_cs_n;
    logic                       color_cs_n;
    logic                       io_cs_n;
    logic                       sound_cs_n;
    logic [`F2_SDR_ADDR_W-1:0]  sdr_addr;
    f2_pkg::cpu_data_t          sdr_data;
    logic [1:0]                 sdr_be;
    logic                       sdr_rw;
    logic                       sdr_req;

    logic [31:0]                lfsr = 32'h683f_c663;
    int                         mismatch_count = 0;
    int                         other_count = 0;
    int                         req_flips = 0;
    int                         exp_region;
    logic [4:0]                 exp_cs;
    logic [4:0]                 cs_bus;
    f2_pkg::cpu_data_t          exp_din;
    logic                       periph_cycle;

    f2_cpu_bus u_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Memory map on the byte address
    function automatic int region_of(input logic [`F2_ADDR_W-1:0] a);
        logic [`F2_ADDR_W:0] b;
        b = {a, 1'b0};
        case (b[23:20])
            4'h0: return R_ROM;
            4'h1: return R_WORK;
            4'h2: return R_COLOR;
            4'h8: return R_SCREEN;
            4'h9: return R_OBJECT;
            4'h3: return (b[19:16] == 4'h0) ? R_IO : (b[19:16] == 4'h2) ? R_SOUND : R_NONE;
            default: return R_NONE;
        endcase
    endfunction

    function automatic logic [`F2_ADDR_W-1:0] addr_in(input int region);
        case (region)
            R_ROM:    return {4'h0, 19'(lfsr_bits(19))};
            R_WORK:   return {4'h1, 19'(lfsr_bits(19))};
            R_SCREEN: return {4'h8, 19'(lfsr_bits(19))};
            R_OBJECT: return {4'h9, 19'(lfsr_bits(19))};
            R_COLOR:  return {4'h2, 19'(lfsr_bits(19))};
            R_IO:     return {8'h30, 15'(lfsr_bits(15))};
            R_SOUND:  return {8'h32, 15'(lfsr_bits(15))};
            default:  return {8'h31, 15'(lfsr_bits(15))};
        endcase
    endfunction

    function automatic logic [`F2_SDR_ADDR_W-1:0] sdram_addr(input logic [`F2_ADDR_W-1:0] a);
        return `F2_CPU_ROM_SDR_BASE + {3'b000, a, 1'b0};
    endfunction

    function automatic f2_pkg::cpu_data_t mem_word(input logic [`F2_SDR_ADDR_W-1:0] a);
        return a[16:1] ^ {5'h00, a[26:16]} ^ 16'h3c5a;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Expected decode

    assign exp_region   = region_of(cpu_addr);
    assign cs_bus       = {scn_cs_n, obj_cs_n, color_cs_n, io_cs_n, sound_cs_n};
    assign exp_cs       = {exp_region != R_SCREEN, exp_region != R_OBJECT,
                           exp_region != R_COLOR, exp_region != R_IO, exp_region != R_SOUND};
    assign periph_cycle = !(&cpu_ds_n) && exp_region > R_WORK;

    always_comb begin
        case (exp_region)
            R_ROM, R_WORK: exp_din = sdr_q;
            R_SCREEN:      exp_din = scn_dout;
            R_OBJECT:      exp_din = obj_dout;
            R_COLOR:       exp_din = color_dout;
            R_IO:          exp_din = {8'h00, io_dout};
            R_SOUND:       exp_din = {4'h0, sound_dout, 8'h00};
            default:       exp_din = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        cs_bus == (&cpu_ds_n ? 5'h1f : exp_cs))
        else report_mismatch("chip selects do not match the address");
    assert property (@(posedge clk) disable iff (reset) !(&cpu_ds_n) |-> cpu_din == exp_din)
        else report_mismatch("cpu_din does not match the selected source");

    // Outstanding request holds DTACK and a stable request
    assert property (@(posedge clk) disable iff (reset) (sdr_req != sdr_ack) |->
        cpu_dtack_n && sdr_addr == sdram_addr(cpu_addr) && sdr_be == ~cpu_ds_n
        && sdr_rw == cpu_rw && sdr_data == cpu_dout)
        else report_mismatch("SDRAM request or DTACK wrong while outstanding");

    // No DTACK before the request goes out
    assert property (@(posedge clk) disable iff (reset)
        !(&cpu_ds_n) && exp_region <= R_WORK && $past(&cpu_ds_n) |-> cpu_dtack_n)
        else report_mismatch("DTACK low before the SDRAM request was issued");

    assert property (@(posedge clk) disable iff (reset)
        (!scn_cs_n && scn_dtack_n) || (!color_cs_n && color_dtack_n) || (!obj_cs_n && obj_busy)
        |-> cpu_dtack_n)
        else report_mismatch("DTACK low while the peripheral is not ready");
    assert property (@(posedge clk) disable iff (reset) periph_cycle && !scn_dtack_n
        && !color_dtack_n && !obj_busy && sdr_req == sdr_ack |-> !cpu_dtack_n)
        else report_mismatch("DTACK high although the peripheral is ready");

    assert property (@(posedge clk) disable iff (reset)
        cpu_vpa_n == !(&cpu_fc && !(&cpu_ds_n)))
        else report_mismatch("VPA does not follow the acknowledge cycle");
    assert property (@(posedge clk) disable iff (reset)
        cpu_ipl_n inside {3'b111, ~`F2_IRQ_VBL, ~`F2_IRQ_DMA})
        else report_mismatch("illegal IPL code");

    ////////////////////////////////////////////////////////////////////////////
    // SDRAM model

    always @(sdr_req) begin
        if (!reset) begin
            req_flips++;
        end
    end

    initial begin
        int delay;
        forever begin
            @(posedge clk);
            #5;
            if (!reset && sdr_req != sdr_ack) begin
                delay = int'(lfsr_bits(3));
                repeat (delay) @(posedge clk);
                if (delay != 0) begin
                    #5;
                end
                sdr_q   = mem_word(sdr_addr);
                sdr_ack = sdr_req;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // CPU model

    // Starts and ends 5 ns after a rising edge, with one idle edge at the end
    task automatic bus_cycle(input logic [`F2_ADDR_W-1:0] addr, input logic [1:0] ds_n,
                             input logic rw, input logic [2:0] fc);
        int   region;
        int   stall;
        int   flips;
        int   waited;
        logic acked;
        region     = region_of(addr);
        stall      = int'(lfsr_bits(2));
        flips      = req_flips;
        waited     = 0;
        cpu_addr   = addr;
        cpu_ds_n   = ds_n;
        cpu_rw     = rw;
        cpu_fc     = fc;
        cpu_dout   = 16'(lfsr_bits(16));
        scn_dout   = 16'(lfsr_bits(16));
        obj_dout   = 16'(lfsr_bits(16));
        color_dout = 16'(lfsr_bits(16));
        io_dout    = 8'(lfsr_bits(8));
        sound_dout = 4'(lfsr_bits(4));
        scn_dtack_n   = region == R_SCREEN && stall != 0;
        color_dtack_n = region == R_COLOR && stall != 0;
        obj_busy      = region == R_OBJECT && stall != 0;
        do begin
            @(negedge clk);
            acked = !cpu_dtack_n || !cpu_vpa_n;
            if (acked && rw && region <= R_WORK) begin
                assert (cpu_din == mem_word(sdram_addr(addr)))
                    else report_mismatch("read data from SDRAM is wrong");
            end
            @(posedge clk);
            #5;
            waited++;
            stall = (stall > 0) ? stall - 1 : 0;
            if (stall == 0) begin
                scn_dtack_n   = 1'b0;
                color_dtack_n = 1'b0;
                obj_busy      = 1'b0;
            end
        end while (!acked && waited < 100);
        if (!acked) begin
            other_count++;
            $display("Bus cycle at byte address %h was never acknowledged", {addr, 1'b0});
        end
        assert (req_flips - flips == ((region <= R_WORK) ? 1 : 0))
            else report_mismatch("wrong number of SDRAM requests in one bus cycle");
        cpu_ds_n = 2'b11;
        cpu_fc   = 3'b101;
        @(posedge clk);
        #5;
    endtask

    task automatic irq_ack(input f2_pkg::irq_level_t level);
        cpu_fc = 3'b111; // FC valid a cycle ahead of the strobes
        @(posedge clk);
        #5;
        bus_cycle({20'hf_ffff, level}, 2'b10, 1'b1, 3'b111);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        logic [1:0] ds;
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;
        assert (cpu_ipl_n == 3'b111) else report_mismatch("interrupt pending after reset");

        for (int i = 0; i < ROUNDS; i++) begin
            for (int r = R_ROM; r <= R_NONE; r++) begin
                ds = 2'(lfsr_bits(2));
                if (ds == 2'b11) begin
                    ds = 2'b00;
                end
                bus_cycle(addr_in(r), ds, lfsr_bits(1) != 0, 3'b101);
            end
        end

        vblank_n = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        assert (cpu_ipl_n == ~`F2_IRQ_VBL) else report_mismatch("blank edge did not raise 5");
        dma_n = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        assert (cpu_ipl_n == ~`F2_IRQ_DMA) else report_mismatch("DMA edge did not raise 6");
        irq_ack(`F2_IRQ_DMA);
        assert (cpu_ipl_n == ~`F2_IRQ_VBL) else report_mismatch("level 5 lost on ack of 6");
        irq_ack(`F2_IRQ_VBL);
        assert (cpu_ipl_n == 3'b111) else report_mismatch("level 5 not cleared by its ack");

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(100 * (200 * BUS_CYCLES + 100));
        $display("Timeout: the bus cycles did not finish in time");
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
